// File: common/eth_rx_pkg.sv
// ------------------------------------------------
// shared constants and types for the XGMII receive
// MAC: control characters, CRC-32 values, receiver
// states and statistics register offsets
// ------------------------------------------------

`default_nettype none

package eth_rx_pkg;

    // XGMII control characters
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;
    localparam logic [7:0] XGMII_ERROR = 8'hfe;

    // Ethernet CRC-32
    localparam logic [31:0] CRC_POLY    = 32'h04c11db7;
    localparam logic [31:0] CRC_INIT    = 32'hffffffff;
    // state left after running over payload plus a correct FCS
    localparam logic [31:0] CRC_RESIDUE = ~32'h2144df1c;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_PAYLOAD,
        RX_LAST
    } rx_state_e;

    // byte offsets of the statistics registers
    typedef enum logic [3:0] {
        REG_FRAMES_OK  = 4'h0,
        REG_FRAMES_BAD = 4'h4,
        REG_FCS_ERRORS = 4'h8,
        REG_CONTROL    = 4'hc
    } stat_reg_e;

endpackage

`default_nettype wire

// File: rtl/crc32_lfsr.sv
// ------------------------------------------------
// combinational Ethernet CRC-32 step, reflected
// Galois form; advances the state over DATA_BYTES
// bytes, lowest byte and lowest bit first
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module crc32_lfsr
    import eth_rx_pkg::*;
#(
    parameter int DATA_BYTES = 4
) (
    input  wire  [DATA_BYTES*8-1:0] data_in,
    input  wire  [31:0]             state_in,
    output logic [31:0]             state_out
);

    // polynomial bit-reversed for the right-shifting register
    localparam logic [31:0] POLY_REFL = {<<{CRC_POLY}};

    logic [31:0] crc;
    logic        feedback;

    always_comb begin
        crc = state_in;
        feedback = 1'b0;
        // one shift per input bit, fully unrolled
        for (int i = 0; i < DATA_BYTES * 8; i++) begin
            feedback = crc[0] ^ data_in[i];
            crc = {1'b0, crc[31:1]};
            if (feedback) begin
                crc = crc ^ POLY_REFL;
            end
        end
        state_out = crc;
    end

endmodule

`default_nettype wire

// File: xgmii_rx_framer/xgmii_rx_framer.sv
// ------------------------------------------------
// 32-bit XGMII frame receiver; strips preamble and
// FCS, checks the CRC and drives an AXI4-Stream
// without back-pressure plus per-frame error pulses
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module xgmii_rx_framer
    import eth_rx_pkg::*;
(
    input  wire         clk,
    input  wire         reset_crc,
    input  wire  [31:0] xgmii_rxd,
    input  wire  [3:0]  xgmii_rxc,
    output logic [31:0] m_axis_tdata,
    output logic [3:0]  m_axis_tkeep,
    output logic        m_axis_tvalid,
    output logic        m_axis_tlast,
    output logic        m_axis_tuser,
    output logic        error_bad_frame,
    output logic        error_bad_fcs
);

    // d0 is the newest word, d2 the one being emitted
    logic [31:0] rxd_d0, rxd_d1, rxd_d2;
    logic [3:0]  rxc_d0, rxc_d1, rxc_d2;

    rx_state_e state, state_next;

    logic        crc_clear;
    logic        crc_update;
    logic [31:0] crc_state;
    logic [31:0] crc_next [4];
    logic [3:0]  crc_ok;
    logic [3:0]  crc_ok_save;

    logic [3:0]  detect_term;
    logic [3:1]  term_save;
    logic [3:0]  keep_mask;
    logic [3:0]  control_masked;
    logic [3:0]  last_tkeep, last_tkeep_next;
    logic        start_d2;
    logic        last_crc_good;
    logic        runt_beat;

    logic [31:0] tdata_next;
    logic [3:0]  tkeep_next;
    logic        tvalid_next, tlast_next, tuser_next;
    logic        bad_frame_next, bad_fcs_next;

    // partial results for 1..4 bytes of the newest word
    for (genvar i = 0; i < 4; i++) begin : g_crc
        crc32_lfsr #(
            .DATA_BYTES(i + 1)
        ) i_crc (
            .data_in  (rxd_d0[8*i+7:0]),
            .state_in (crc_state),
            .state_out(crc_next[i])
        );
        assign crc_ok[i] = (crc_next[i] == CRC_RESIDUE);
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            detect_term[i] = rxc_d0[i] && (rxd_d0[8*i +: 8] == XGMII_TERM);
        end
    end

    // lanes before the first terminate are still frame data
    always_comb begin
        casez (detect_term)
            4'b???1: keep_mask = 4'b0000;
            4'b??10: keep_mask = 4'b0001;
            4'b?100: keep_mask = 4'b0011;
            4'b1000: keep_mask = 4'b0111;
            default: keep_mask = 4'b1111;
        endcase
    end

    assign control_masked = rxc_d0 & keep_mask;
    assign start_d2 = rxc_d2[0] && (rxd_d2[7:0] == XGMII_START);
    // terminate in lane k leaves k bytes to run through the CRC
    assign last_crc_good = |(term_save[3:1] & crc_ok_save[2:0]);

    always_comb begin
        state_next = state;
        crc_clear = 1'b0;
        crc_update = 1'b0;
        runt_beat = 1'b0;
        last_tkeep_next = last_tkeep;
        tdata_next = rxd_d2;
        tkeep_next = 4'b1111;
        tvalid_next = 1'b0;
        tlast_next = 1'b0;
        tuser_next = 1'b0;
        bad_frame_next = 1'b0;
        bad_fcs_next = 1'b0;

        case (state)
            RX_IDLE: begin
                crc_clear = 1'b1;
                if (start_d2) begin
                    if (control_masked != 4'b0000) begin
                        runt_beat = 1'b1;
                    end else begin
                        crc_clear = 1'b0;
                        crc_update = 1'b1;
                        state_next = RX_PREAMBLE;
                    end
                end
            end
            RX_PREAMBLE: begin
                // frame already broken before the first beat
                if (control_masked != 4'b0000 || detect_term != 4'b0000) begin
                    runt_beat = 1'b1;
                    crc_clear = 1'b1;
                    state_next = RX_IDLE;
                end else begin
                    crc_update = 1'b1;
                    state_next = RX_PAYLOAD;
                end
            end
            RX_PAYLOAD: begin
                crc_update = 1'b1;
                tvalid_next = 1'b1;
                if (control_masked != 4'b0000) begin
                    tlast_next = 1'b1;
                    tuser_next = 1'b1;
                    bad_frame_next = 1'b1;
                    crc_clear = 1'b1;
                    state_next = RX_IDLE;
                end else if (detect_term[0]) begin
                    // FCS sat in d1, so d2 is a full last beat
                    tlast_next = 1'b1;
                    crc_clear = 1'b1;
                    if (!crc_ok_save[3]) begin
                        tuser_next = 1'b1;
                        bad_frame_next = 1'b1;
                        bad_fcs_next = 1'b1;
                    end
                    state_next = RX_IDLE;
                end else if (detect_term != 4'b0000) begin
                    last_tkeep_next = keep_mask;
                    state_next = RX_LAST;
                end
            end
            RX_LAST: begin
                crc_clear = 1'b1;
                tvalid_next = 1'b1;
                tlast_next = 1'b1;
                tkeep_next = last_tkeep;
                if (!last_crc_good) begin
                    tuser_next = 1'b1;
                    bad_frame_next = 1'b1;
                    bad_fcs_next = 1'b1;
                end
                state_next = RX_IDLE;
            end
            default: begin
                state_next = RX_IDLE;
            end
        endcase

        if (runt_beat) begin
            tdata_next = 32'd0;
            tkeep_next = 4'b0001;
            tvalid_next = 1'b1;
            tlast_next = 1'b1;
            tuser_next = 1'b1;
            bad_frame_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            state <= RX_IDLE;
            rxc_d0 <= 4'b0000;
            rxc_d1 <= 4'b0000;
            rxc_d2 <= 4'b0000;
            crc_state <= CRC_INIT;
            crc_ok_save <= 4'b0000;
            m_axis_tvalid <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs <= 1'b0;
        end else begin
            state <= state_next;
            rxc_d0 <= xgmii_rxc;
            rxc_d1 <= rxc_d0;
            rxc_d2 <= rxc_d1;
            if (crc_clear) begin
                crc_state <= CRC_INIT;
                crc_ok_save <= 4'b0000;
            end else if (crc_update) begin
                crc_state <= crc_next[3];
                crc_ok_save <= crc_ok;
            end
            m_axis_tvalid <= tvalid_next;
            error_bad_frame <= bad_frame_next;
            error_bad_fcs <= bad_fcs_next;
        end
    end

    always_ff @(posedge clk) begin
        rxd_d0 <= xgmii_rxd;
        rxd_d1 <= rxd_d0;
        rxd_d2 <= rxd_d1;
        term_save <= detect_term[3:1];
        last_tkeep <= last_tkeep_next;
        m_axis_tdata <= tdata_next;
        m_axis_tkeep <= tkeep_next;
        m_axis_tlast <= tlast_next;
        m_axis_tuser <= tuser_next;
    end

endmodule

`default_nettype wire

// File: rtl/rx_stats_axil.sv
// ------------------------------------------------
// receive statistics: good frames, bad frames and
// FCS errors, read and cleared over AXI4-Lite
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rx_stats_axil
    import eth_rx_pkg::*;
#(
    parameter int COUNT_WIDTH     = 32,
    parameter int AXIL_ADDR_WIDTH = 4
) (
    input  wire                       clk,
    input  wire                       reset_crc,
    input  wire                       m_axis_tvalid,
    input  wire                       m_axis_tlast,
    input  wire                       m_axis_tuser,
    input  wire                       error_bad_fcs,
    input  wire [AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
    input  wire                       s_axil_awvalid,
    output logic                      s_axil_awready,
    input  wire [31:0]                s_axil_wdata,
    input  wire [3:0]                 s_axil_wstrb,
    input  wire                       s_axil_wvalid,
    output logic                      s_axil_wready,
    output logic [1:0]                s_axil_bresp,
    output logic                      s_axil_bvalid,
    input  wire                       s_axil_bready,
    input  wire [AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
    input  wire                       s_axil_arvalid,
    output logic                      s_axil_arready,
    output logic [31:0]               s_axil_rdata,
    output logic [1:0]                s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  wire                       s_axil_rready
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic                   wr_fire;
    logic                   rd_fire;
    logic                   clear_counts;
    logic [31:0]            rd_value;
    logic [COUNT_WIDTH-1:0] frames_ok, frames_bad, fcs_errors;

    function automatic logic [COUNT_WIDTH-1:0] sat_inc(input logic [COUNT_WIDTH-1:0] value,
                                                      input logic hit);
        // stick at all ones
        sat_inc = (hit && value != '1) ? value + 1'b1 : value;
    endfunction

    // address and data are taken in the same cycle
    assign wr_fire = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_fire;
    assign s_axil_wready = wr_fire;
    assign s_axil_bresp = RESP_OKAY;

    assign clear_counts = wr_fire && ((s_axil_awaddr >> 4) == '0) &&
                          (stat_reg_e'(s_axil_awaddr[3:0]) == REG_CONTROL) &&
                          s_axil_wstrb[0] && s_axil_wdata[0];

    assign s_axil_arready = !s_axil_rvalid;
    assign rd_fire = s_axil_arvalid && s_axil_arready;
    assign s_axil_rresp = RESP_OKAY;

    always_comb begin
        rd_value = 32'd0;
        if ((s_axil_araddr >> 4) == '0) begin
            case (stat_reg_e'(s_axil_araddr[3:0]))
                REG_FRAMES_OK:  rd_value = 32'(frames_ok);
                REG_FRAMES_BAD: rd_value = 32'(frames_bad);
                REG_FCS_ERRORS: rd_value = 32'(fcs_errors);
                default:        rd_value = 32'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            frames_ok <= '0;
            frames_bad <= '0;
            fcs_errors <= '0;
        end else if (clear_counts) begin
            frames_ok <= '0;
            frames_bad <= '0;
            fcs_errors <= '0;
        end else begin
            frames_ok <= sat_inc(frames_ok, m_axis_tvalid && m_axis_tlast && !m_axis_tuser);
            frames_bad <= sat_inc(frames_bad, m_axis_tvalid && m_axis_tlast && m_axis_tuser);
            fcs_errors <= sat_inc(fcs_errors, error_bad_fcs);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_crc) begin
            s_axil_bvalid <= 1'b0;
            s_axil_rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                s_axil_bvalid <= 1'b1;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end
            if (rd_fire) begin
                s_axil_rvalid <= 1'b1;
            end else if (s_axil_rready) begin
                s_axil_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            s_axil_rdata <= rd_value;
        end
    end

endmodule

`default_nettype wire

// File: rtl/eth_xgmii_rx_top.sv
// ------------------------------------------------
// 10G Ethernet receive MAC top: XGMII framer with
// its statistics block on an AXI4-Lite port
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module eth_xgmii_rx_top #(
    parameter int COUNT_WIDTH     = 32,
    parameter int AXIL_ADDR_WIDTH = 4
) (
    input  wire                       clk,
    input  wire                       reset_crc,
    input  wire  [31:0]               xgmii_rxd,
    input  wire  [3:0]                xgmii_rxc,
    output logic [31:0]               m_axis_tdata,
    output logic [3:0]                m_axis_tkeep,
    output logic                      m_axis_tvalid,
    output logic                      m_axis_tlast,
    output logic                      m_axis_tuser,
    output logic                      error_bad_frame,
    output logic                      error_bad_fcs,
    input  wire  [AXIL_ADDR_WIDTH-1:0] s_axil_awaddr,
    input  wire                       s_axil_awvalid,
    output logic                      s_axil_awready,
    input  wire  [31:0]               s_axil_wdata,
    input  wire  [3:0]                s_axil_wstrb,
    input  wire                       s_axil_wvalid,
    output logic                      s_axil_wready,
    output logic [1:0]                s_axil_bresp,
    output logic                      s_axil_bvalid,
    input  wire                       s_axil_bready,
    input  wire  [AXIL_ADDR_WIDTH-1:0] s_axil_araddr,
    input  wire                       s_axil_arvalid,
    output logic                      s_axil_arready,
    output logic [31:0]               s_axil_rdata,
    output logic [1:0]                s_axil_rresp,
    output logic                      s_axil_rvalid,
    input  wire                       s_axil_rready
);

    xgmii_rx_framer i_framer (
        .clk            (clk),
        .reset_crc      (reset_crc),
        .xgmii_rxd      (xgmii_rxd),
        .xgmii_rxc      (xgmii_rxc),
        .m_axis_tdata   (m_axis_tdata),
        .m_axis_tkeep   (m_axis_tkeep),
        .m_axis_tvalid  (m_axis_tvalid),
        .m_axis_tlast   (m_axis_tlast),
        .m_axis_tuser   (m_axis_tuser),
        .error_bad_frame(error_bad_frame),
        .error_bad_fcs  (error_bad_fcs)
    );

    // counters watch the stream as it leaves the framer
    rx_stats_axil #(
        .COUNT_WIDTH    (COUNT_WIDTH),
        .AXIL_ADDR_WIDTH(AXIL_ADDR_WIDTH)
    ) i_stats (
        .clk           (clk),
        .reset_crc     (reset_crc),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .error_bad_fcs (error_bad_fcs),
        .s_axil_awaddr (s_axil_awaddr),
        .s_axil_awvalid(s_axil_awvalid),
        .s_axil_awready(s_axil_awready),
        .s_axil_wdata  (s_axil_wdata),
        .s_axil_wstrb  (s_axil_wstrb),
        .s_axil_wvalid (s_axil_wvalid),
        .s_axil_wready (s_axil_wready),
        .s_axil_bresp  (s_axil_bresp),
        .s_axil_bvalid (s_axil_bvalid),
        .s_axil_bready (s_axil_bready),
        .s_axil_araddr (s_axil_araddr),
        .s_axil_arvalid(s_axil_arvalid),
        .s_axil_arready(s_axil_arready),
        .s_axil_rdata  (s_axil_rdata),
        .s_axil_rresp  (s_axil_rresp),
        .s_axil_rvalid (s_axil_rvalid),
        .s_axil_rready (s_axil_rready)
    );

endmodule

`default_nettype wire

// File: dv/tb_eth_xgmii_rx.sv
// ------------------------------------------------
// testbench for the XGMII receive MAC: drives the
// frames of dv/rx_frames_input.txt, checks every
// stream beat and error pulse, then the counters
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_eth_xgmii_rx
    import eth_rx_pkg::*;
();

    localparam int          WAIT_LIMIT = 1000;
    localparam logic [31:0] IDLE_WORD  = {4{XGMII_IDLE}};
    localparam logic [31:0] START_WORD = {8'h55, 8'h55, 8'h55, XGMII_START};
    localparam logic [31:0] SFD_WORD   = 32'hd5555555;

    logic        clk;
    logic        reset_crc;
    logic [31:0] xgmii_rxd;
    logic [3:0]  xgmii_rxc;
    logic [31:0] m_axis_tdata;
    logic [3:0]  m_axis_tkeep;
    logic        m_axis_tvalid, m_axis_tlast, m_axis_tuser;
    logic        error_bad_frame, error_bad_fcs;
    logic [3:0]  s_axil_awaddr, s_axil_araddr;
    logic        s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic [31:0] s_axil_wdata, s_axil_rdata;
    logic [3:0]  s_axil_wstrb;
    logic [1:0]  s_axil_bresp, s_axil_rresp;
    logic        s_axil_bvalid, s_axil_bready;
    logic        s_axil_arvalid, s_axil_arready, s_axil_rvalid, s_axil_rready;

    // {gap marker, rxc, rxd} and {tdata, tkeep, tlast, tuser, bad_frame, bad_fcs}
    logic [36:0] drive_q [$];
    logic [39:0] expect_q [$];
    logic [31:0] exp_ok, exp_bad, exp_fcs;
    int          beats_seen = 0;
    logic        monitor_on = 1'b0;

    eth_xgmii_rx_top #(
        .COUNT_WIDTH    (32),
        .AXIL_ADDR_WIDTH(4)
    ) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail %s: expected %h, actual %h", name, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_error(input string what);
        $display("Error: %s", what);
        stop_on_failure();
    endtask

    function automatic logic [31:0] byte_mask(input logic [3:0] keep);
        for (int i = 0; i < 4; i++) begin
            byte_mask[8*i +: 8] = {8{keep[i]}};
        end
    endfunction

    task automatic load_stimulus();
        int              fd;
        int              code;
        int              count;
        logic [7:0]      tag;
        logic [8*160-1:0] rest;
        logic [31:0]     rxd, e_data;
        logic [3:0]      rxc, e_keep;
        logic            e_last, e_user, e_bframe, e_bfcs;
        fd = $fopen("dv/rx_frames_input.txt", "r");
        assert (fd != 0) else report_error("cannot open dv/rx_frames_input.txt");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(rest, fd);
            end else if (tag == "G") begin
                drive_q.push_back({1'b1, 36'd0});
            end else if (tag == "F") begin
                code = $fscanf(fd, "%d", count);
                drive_q.push_back({1'b0, 4'b0001, START_WORD});
                drive_q.push_back({1'b0, 4'b0000, SFD_WORD});
                for (int i = 0; i < count; i++) begin
                    code = $fscanf(fd, "%h %h", rxd, rxc);
                    assert (code == 2) else report_error("short frame line in stimulus file");
                    drive_q.push_back({1'b0, rxc, rxd});
                end
            end else if (tag == "E") begin
                code = $fscanf(fd, "%h %h %h %h %h %h", e_data, e_keep, e_last, e_user,
                               e_bframe, e_bfcs);
                assert (code == 6) else report_error("short beat line in stimulus file");
                expect_q.push_back({e_data, e_keep, e_last, e_user, e_bframe, e_bfcs});
            end else if (tag == "C") begin
                code = $fscanf(fd, "%d %d %d", exp_ok, exp_bad, exp_fcs);
                assert (code == 3) else report_error("short counter line in stimulus file");
            end else begin
                report_error("unknown line tag in stimulus file");
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_word(input logic [31:0] rxd, input logic [3:0] rxc);
        @(posedge clk);
        #1;
        xgmii_rxd = rxd;
        xgmii_rxc = rxc;
    endtask

    task automatic drive_stimulus();
        logic [36:0] item;
        int          gap;
        while (drive_q.size() > 0) begin
            item = drive_q.pop_front();
            if (item[36]) begin
                gap = ($urandom % 4) + 1;
                repeat (gap) begin
                    drive_word(IDLE_WORD, 4'hf);
                end
            end else begin
                drive_word(item[31:0], item[35:32]);
            end
        end
        drive_word(IDLE_WORD, 4'hf);
    endtask

    task automatic check_idle_outputs(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!m_axis_tvalid && !s_axil_bvalid && !s_axil_rvalid)
                else report_error("a valid output rose while only idle words were driven");
        end
    endtask

    task automatic wait_stream_done();
        int waited;
        waited = 0;
        while (expect_q.size() > 0) begin
            @(negedge clk);
            waited++;
            assert (waited < WAIT_LIMIT) else report_error("timeout waiting for stream beats");
        end
        // room for any stray beat to show up
        check_idle_outputs(8);
    endtask

    // compare each beat in order; outputs are settled at the falling edge
    always @(negedge clk) begin : stream_monitor
        logic [39:0] exp_beat;
        string       name;
        if (monitor_on) begin
            if (m_axis_tvalid) begin
                assert (expect_q.size() > 0) else report_error("stream beat with none expected");
                exp_beat = expect_q.pop_front();
                beats_seen++;
                name = $sformatf("beat %0d", beats_seen);
                assert (m_axis_tkeep == exp_beat[7:4])
                    else report_mismatch({name, " tkeep"}, 32'(exp_beat[7:4]),
                                         32'(m_axis_tkeep));
                assert ((m_axis_tdata & byte_mask(m_axis_tkeep)) == exp_beat[39:8])
                    else report_mismatch({name, " tdata"}, exp_beat[39:8],
                                         m_axis_tdata & byte_mask(m_axis_tkeep));
                assert (m_axis_tlast == exp_beat[3])
                    else report_mismatch({name, " tlast"}, 32'(exp_beat[3]), 32'(m_axis_tlast));
                assert (m_axis_tuser == exp_beat[2])
                    else report_mismatch({name, " tuser"}, 32'(exp_beat[2]), 32'(m_axis_tuser));
                assert (error_bad_frame == exp_beat[1])
                    else report_mismatch({name, " error_bad_frame"}, 32'(exp_beat[1]),
                                         32'(error_bad_frame));
                assert (error_bad_fcs == exp_beat[0])
                    else report_mismatch({name, " error_bad_fcs"}, 32'(exp_beat[0]),
                                         32'(error_bad_fcs));
            end else begin
                assert (!error_bad_frame && !error_bad_fcs)
                    else report_error("error pulse without a stream beat");
            end
        end
    end

    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        int waited;
        @(posedge clk);
        #1;
        s_axil_awaddr = addr;
        s_axil_wdata = data;
        s_axil_wstrb = 4'hf;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!(s_axil_awready && s_axil_wready)) begin
            waited++;
            assert (waited < WAIT_LIMIT) else report_error("timeout waiting for awready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        s_axil_awvalid = 1'b0;
        s_axil_wvalid = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!s_axil_bvalid) begin
            waited++;
            assert (waited < WAIT_LIMIT) else report_error("timeout waiting for bvalid");
            @(negedge clk);
        end
        assert (s_axil_bresp == 2'b00) else report_mismatch("bresp", 32'd0, 32'(s_axil_bresp));
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        int waited;
        @(posedge clk);
        #1;
        s_axil_araddr = addr;
        s_axil_arvalid = 1'b1;
        waited = 0;
        @(negedge clk);
        while (!s_axil_arready) begin
            waited++;
            assert (waited < WAIT_LIMIT) else report_error("timeout waiting for arready");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        s_axil_arvalid = 1'b0;
        waited = 0;
        @(negedge clk);
        while (!s_axil_rvalid) begin
            waited++;
            assert (waited < WAIT_LIMIT) else report_error("timeout waiting for rvalid");
            @(negedge clk);
        end
        assert (s_axil_rresp == 2'b00) else report_mismatch("rresp", 32'd0, 32'(s_axil_rresp));
        data = s_axil_rdata;
    endtask

    task automatic check_read(input logic [3:0] addr, input string name,
                              input logic [31:0] expected);
        logic [31:0] value;
        axil_read(addr, value);
        assert (value == expected) else report_mismatch(name, expected, value);
    endtask

    task automatic check_registers();
        // writes to a counter offset are ignored
        axil_write(REG_FRAMES_OK, 32'd1);
        check_read(REG_FRAMES_OK, "read frames_ok", exp_ok);
        check_read(REG_FRAMES_BAD, "read frames_bad", exp_bad);
        check_read(REG_FCS_ERRORS, "read fcs_errors", exp_fcs);
        check_read(REG_CONTROL, "read control", 32'd0);
        check_read(4'h2, "read offset 0x2", 32'd0);
        check_read(4'h6, "read offset 0x6", 32'd0);
        axil_write(REG_CONTROL, 32'd1);
        check_read(REG_FRAMES_OK, "cleared frames_ok", 32'd0);
        check_read(REG_FRAMES_BAD, "cleared frames_bad", 32'd0);
        check_read(REG_FCS_ERRORS, "cleared fcs_errors", 32'd0);
    endtask

    initial begin
        reset_crc = 1'b1;
        xgmii_rxd = IDLE_WORD;
        xgmii_rxc = 4'hf;
        s_axil_awaddr = 4'h0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata = 32'd0;
        s_axil_wstrb = 4'h0;
        s_axil_wvalid = 1'b0;
        s_axil_bready = 1'b1;
        s_axil_araddr = 4'h0;
        s_axil_arvalid = 1'b0;
        s_axil_rready = 1'b1;
        void'($urandom(32'hd0d93eba));
        load_stimulus();

        repeat (4) @(posedge clk);
        #1;
        reset_crc = 1'b0;

        check_idle_outputs(8);
        monitor_on = 1'b1;
        drive_stimulus();
        wait_stream_done();
        check_registers();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: eth_xgmii_rx.f
common/eth_rx_pkg.sv
rtl/crc32_lfsr.sv
xgmii_rx_framer/xgmii_rx_framer.sv
rtl/rx_stats_axil.sv
rtl/eth_xgmii_rx_top.sv
dv/tb_eth_xgmii_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build the XGMII receive testbench with Verilator and run it.
# The script's exit status is the simulator's exit status.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_eth_xgmii_rx \
    -f eth_xgmii_rx.f \
    -o tb_eth_xgmii_rx
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_eth_xgmii_rx
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation ended with status $status"
fi
exit "$status"

// File: dv/rx_frames_input.txt
# F n: start and preamble words, then n words "rxd rxc"; G: 1 to 4 random idle words
# E: tdata tkeep tlast tuser bad_frame bad_fcs (hex); C: frames_ok frames_bad fcs_errors
G
F 3 74736574 0 d87f7e0c 0 070707fd f
E 74736574 f 1 0 0 0
G
F 4 34333231 0 38373635 0 f4392639 0 0707fdcb e
E 34333231 f 0 0 0 0
E 38373635 f 0 0 0 0
E 00000039 1 1 0 0 0
F 4 6c6c6568 0 6f77206f 0 85646c72 0 fd0d4a11 8
E 6c6c6568 f 0 0 0 0
E 6f77206f f 0 0 0 0
E 00646c72 7 1 0 0 0
G
F 5 7373656d 0 20656761 0 65676964 0 9d7f7473 0 07fd2015 c
E 7373656d f 0 0 0 0
E 20656761 f 0 0 0 0
E 65676964 f 0 0 0 0
E 00007473 3 1 0 0 0
G
F 4 34333231 0 38373635 0 f4392739 0 0707fdcb e
E 34333231 f 0 0 0 0
E 38373635 f 0 0 0 0
E 00000039 1 1 1 1 1
F 4 04030201 0 08070605 0 0c0bfe09 2 070707fd f
E 04030201 f 1 1 1 0
F 3 74736574 0 d87f7e0c 0 070707fd f
E 74736574 f 1 0 0 0
G
C 5 2 1
